//--- list.f
+incdir+include
verilog/st_cfg_pkg.sv
verilog/st_bus_pkg.sv
verilog/st_cfg_decode.sv
verilog/viking_detect.sv
verilog/upload_writer.sv
verilog/ram_window.sv
verilog/sdram_port_mux.sv
verilog/st_mem_top.sv
bench/tb_clock.sv
bench/st_mem_tb.sv

//--- bench/st_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module st_mem_tb
	import st_cfg_pkg::*;
	import st_bus_pkg::*;
();

	logic          clk_32;
	logic          xsint;
	sys_ctrl_t     system_ctrl;
	logic          mhz8_en1;
	logic          as_n;
	word_addr_t    mbus_a;
	bus_cycle_t    bus_cycle;
	logic          rom2_n;
	logic          dio_strobe;
	logic          dio_download;
	word_addr_t    dio_addr;
	data_t         dio_data;
	logic          viking_read;
	word_addr_t    viking_vaddr;
	logic          ras_n;
	word_addr_t    ram_a;
	logic          ram_we_n;
	ds_t           ram_ds;
	data_t         ram_din;
	word_addr_t    sdram_addr;
	logic          sdram_req;
	logic          sdram_we;
	ds_t           sdram_ds;
	data_t         sdram_din;
	word_addr_t    rom_addr;
	logic          viking_active;
	logic          tos192k;

	logic [15:0] lfsr = 16'd49; // random source state
	int          test_errors = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	tb_clock u_clk (
		.clk_32 (clk_32),
		.xsint  (xsint)
	);

	st_mem_top dut_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.system_ctrl_i   (system_ctrl),
		.mhz8_en1_i      (mhz8_en1),
		.as_n_i          (as_n),
		.mbus_a_i        (mbus_a),
		.bus_cycle_i     (bus_cycle),
		.rom2_n_i        (rom2_n),
		.dio_strobe_i    (dio_strobe),
		.dio_download_i  (dio_download),
		.dio_addr_i      (dio_addr),
		.dio_data_i      (dio_data),
		.viking_read_i   (viking_read),
		.viking_vaddr_i  (viking_vaddr),
		.ras_n_i         (ras_n),
		.ram_a_i         (ram_a),
		.ram_we_n_i      (ram_we_n),
		.ram_ds_i        (ram_ds),
		.ram_din_i       (ram_din),
		.sdram_addr_o    (sdram_addr),
		.sdram_req_o     (sdram_req),
		.sdram_we_o      (sdram_we),
		.sdram_ds_o      (sdram_ds),
		.sdram_din_o     (sdram_din),
		.rom_addr_o      (rom_addr),
		.viking_active_o (viking_active),
		.tos192k_o       (tos192k)
	);

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// first byte address past st ram, as a word address
	function automatic word_addr_t size_limit(input logic [2:0] code);
		logic [23:0] top;
		case (code)
			3'd0:    top = 24'h080000;
			3'd1:    top = 24'h100000;
			3'd2:    top = 24'h200000;
			3'd3:    top = 24'h400000;
			3'd4:    top = 24'h800000;
			default: top = 24'he00000; // 14m, stops below rom space
		endcase
		return top[23:1];
	endfunction

	task automatic check_addr(input string name, input word_addr_t got, input word_addr_t want);
		if (got !== want) begin
			$display("error %s: got %h, expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t want);
		if (got !== want) begin
			$display("error %s: got %h, expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic check_ds(input string name, input ds_t got, input ds_t want);
		if (got !== want) begin
			$display("error %s: got %h, expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("error %s: got %h, expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %s: ok", name);
		else begin
			$display("test %s: %0d errors", name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	task automatic init_inputs;
		system_ctrl  <= '0;
		mhz8_en1     <= 1'b0;
		as_n         <= 1'b1;
		mbus_a       <= '0;
		bus_cycle    <= OTHER;
		rom2_n       <= 1'b1;
		dio_strobe   <= 1'b0;
		dio_download <= 1'b0;
		dio_addr     <= '0;
		dio_data     <= '0;
		viking_read  <= 1'b0;
		viking_vaddr <= '0;
		ras_n        <= 1'b1; // idle, no edge
		ram_a        <= '0;
		ram_we_n     <= 1'b1;
		ram_ds       <= 2'b00;
		ram_din      <= '0;
	endtask

	task automatic test_reset_state;
		int n;
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (xsint !== 1'b1 && n < 10);
		if (xsint !== 1'b1)
			report_problem("reset was never released");
		@(negedge clk_32);
		check_bit("sdram_req_o", sdram_req, 1'b0);
		check_bit("viking_active_o", viking_active, 1'b0);
		check_bit("tos192k_o", tos192k, 1'b0);
		finish_test("reset_state");
	endtask

	// one ras falling edge, chipset side
	task automatic ras_access(input logic [2:0] code, input word_addr_t a, input logic want);
		logic [31:0] r;
		ds_t         ds;
		logic        we_n;
		data_t       din;
		take_bits(2, r);
		ds = r[1:0];
		take_bits(1, r);
		we_n = r[0];
		take_bits(16, r);
		din = r[15:0];
		@(posedge clk_32);
		system_ctrl <= {28'h0000000, code, 1'b0}; // size in bits 3..1
		ras_n       <= 1'b0;
		ram_a       <= a;
		ram_ds      <= ds;
		ram_we_n    <= we_n;
		ram_din     <= din;
		@(negedge clk_32);
		check_bit("sdram_req_o", sdram_req, want);
		if (want) begin
			check_addr("sdram_addr_o", sdram_addr, a);
			check_ds("sdram_ds_o", sdram_ds, ds);
			check_bit("sdram_we_o", sdram_we, ~we_n);
			check_data("sdram_din_o", sdram_din, din);
		end
		@(posedge clk_32); // ras still low, edge already seen
		@(negedge clk_32);
		check_bit("sdram_req_o", sdram_req, 1'b0); // one cycle only
		@(posedge clk_32);
		ras_n <= 1'b1;
	endtask

	task automatic test_ram_window;
		logic [31:0] r;
		word_addr_t  limit;
		for (int code = 0; code < 6; code++) begin
			limit = size_limit(code[2:0]);
			take_bits(12, r);
			ras_access(code[2:0], limit - 23'd1 - r[11:0], 1'b1); // just inside
			take_bits(12, r);
			ras_access(code[2:0], limit + r[11:0], 1'b0);         // just outside
		end
		ras_access(3'd5, '0, 1'b0); // zero address never requests
		finish_test("ram_window");
	endtask

	// one 8 MHz cpu bus cycle at the given top prefix
	task automatic cpu_access(input logic [5:0] prefix);
		logic [31:0] r;
		take_bits(17, r);
		@(posedge clk_32);
		mhz8_en1 <= 1'b1;
		as_n     <= 1'b0;
		mbus_a   <= {prefix, r[16:0]};
		@(posedge clk_32);
		mhz8_en1 <= 1'b0;
		as_n     <= 1'b1;
	endtask

	task automatic test_viking;
		logic [31:0] r;
		int          n;
		@(posedge clk_32);
		system_ctrl <= 32'h1000_0008; // viking_en, 8m
		repeat (254) cpu_access(6'b110000);
		repeat (3) @(negedge clk_32); // let the flag settle on count 254
		check_bit("viking_active_o", viking_active, 1'b0); // probing is not enough
		cpu_access(6'b110000);
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (viking_active !== 1'b1 && n < 2);
		if (viking_active !== 1'b1)
			report_problem("viking card not active two cycles after the 255th access");
		take_bits(23, r);
		@(posedge clk_32);
		bus_cycle    <= VIKING;
		viking_read  <= 1'b1;
		viking_vaddr <= r[22:0];
		@(negedge clk_32);
		check_bit("sdram_req_o", sdram_req, 1'b1);
		check_addr("sdram_addr_o", sdram_addr, r[22:0]);
		check_bit("sdram_we_o", sdram_we, 1'b0); // video fetch reads
		@(posedge clk_32);
		bus_cycle   <= OTHER;
		viking_read <= 1'b0;
		system_ctrl <= 32'h0000_000b; // soft reset, 14m, viking off
		@(posedge clk_32);
		system_ctrl <= 32'h0000_000a;
		@(negedge clk_32);
		check_bit("viking_active_o", viking_active, 1'b0);
		repeat (300) cpu_access(6'b110000);
		@(negedge clk_32);
		check_bit("viking_active_o", viking_active, 1'b0);
		finish_test("viking");
	endtask

	task automatic test_upload;
		logic [31:0] r;
		word_addr_t  a;
		data_t       d;
		int          n;
		int          hits;
		take_bits(23, r);
		a = r[22:0];
		take_bits(16, r);
		d = r[15:0];
		@(posedge clk_32);
		dio_download <= 1'b1;
		dio_addr     <= a;
		dio_data     <= d;
		bus_cycle    <= PRECYCLE;
		mhz8_en1     <= 1'b1;
		dio_strobe   <= ~dio_strobe; // one word
		@(posedge clk_32);
		bus_cycle <= CPU;
		mhz8_en1  <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (sdram_req !== 1'b1 && n < 4);
		if (sdram_req !== 1'b1)
			report_problem("upload write never reached the sdram port");
		else begin
			check_bit("sdram_we_o", sdram_we, 1'b1);
			check_addr("sdram_addr_o", sdram_addr, a);
			check_ds("sdram_ds_o", sdram_ds, 2'b11);
			check_data("sdram_din_o", sdram_din, d);
		end
		hits = 0;
		repeat (4) begin
			@(negedge clk_32);
			if (sdram_req === 1'b1)
				hits++;
		end
		if (hits != 0)
			report_problem("one strobe toggle gave more than one sdram request");
		// sample again with the strobe unchanged
		@(posedge clk_32);
		bus_cycle <= PRECYCLE;
		mhz8_en1  <= 1'b1;
		@(posedge clk_32);
		bus_cycle <= CPU;
		mhz8_en1  <= 1'b0;
		hits = 0;
		repeat (4) begin
			@(negedge clk_32);
			if (sdram_req === 1'b1)
				hits++;
		end
		if (hits != 0)
			report_problem("sdram request without a strobe toggle");
		@(posedge clk_32);
		dio_download <= 1'b0;
		bus_cycle    <= OTHER;
		finish_test("upload");
	endtask

	task automatic test_tos_remap;
		logic [31:0] r;
		int          n;
		take_bits(17, r);
		@(posedge clk_32);
		dio_download <= 1'b1;
		dio_addr     <= {6'b111111, r[16:0]}; // 192k image area
		@(posedge clk_32);
		dio_download <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (tos192k !== 1'b1 && n < 3);
		check_bit("tos192k_o", tos192k, 1'b1);
		take_bits(23, r);
		@(posedge clk_32);
		rom2_n <= 1'b0;
		mbus_a <= r[22:0];
		@(negedge clk_32);
		check_addr("rom_addr_o", rom_addr, {6'b111111, r[16:0]});
		take_bits(19, r);
		@(posedge clk_32);
		dio_download <= 1'b1;
		dio_addr     <= {4'he, r[18:0]}; // $e00000 image
		@(posedge clk_32);
		dio_download <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_32);
			n++;
		end while (tos192k !== 1'b0 && n < 3);
		check_bit("tos192k_o", tos192k, 1'b0);
		check_addr("rom_addr_o", rom_addr, {6'b111000, mbus_a[17:1]});
		@(posedge clk_32);
		rom2_n <= 1'b1; // no rom select, straight through
		@(negedge clk_32);
		check_addr("rom_addr_o", rom_addr, mbus_a);
		finish_test("tos_remap");
	endtask

	initial begin
		init_inputs();
		test_reset_state();
		test_ram_window();
		test_viking();
		test_upload();
		test_tos_remap();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_32,
	output logic xsint
);

	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32; // 20 ns period
	end

	// reset low for the first three rising edges
	initial begin
		xsint = 1'b0;
		repeat (3) @(posedge clk_32);
		xsint <= 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/st_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module st_mem_top
	import st_cfg_pkg::*;
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  sys_ctrl_t  system_ctrl_i,
	input  logic       mhz8_en1_i,
	input  logic       as_n_i,
	input  word_addr_t mbus_a_i,
	input  bus_cycle_t bus_cycle_i,
	input  logic       rom2_n_i,
	input  logic       dio_strobe_i,
	input  logic       dio_download_i,
	input  word_addr_t dio_addr_i,
	input  data_t      dio_data_i,
	input  logic       viking_read_i,
	input  word_addr_t viking_vaddr_i,
	input  logic       ras_n_i,
	input  word_addr_t ram_a_i,
	input  logic       ram_we_n_i,
	input  ds_t        ram_ds_i,
	input  data_t      ram_din_i,
	output word_addr_t sdram_addr_o,
	output logic       sdram_req_o,
	output logic       sdram_we_o,
	output ds_t        sdram_ds_o,
	output data_t      sdram_din_o,
	output word_addr_t rom_addr_o,
	output logic       viking_active_o,
	output logic       tos192k_o
);

	mem_size_t     mem_size;
	machine_mode_t mode;
	logic          viking_enable;
	logic          soft_reset;
	logic          data_wr;     // upload write pulse
	logic          ram_req_ok;  // chipset address inside window

	st_cfg_decode u_cfg (
		.system_ctrl_i   (system_ctrl_i),
		.mem_size_o      (mem_size),
		.mode_o          (mode),
		.viking_enable_o (viking_enable),
		.soft_reset_o    (soft_reset)
	);

	viking_detect u_viking (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.soft_reset_i    (soft_reset),
		.mhz8_en1_i      (mhz8_en1_i),
		.as_n_i          (as_n_i),
		.mbus_a_i        (mbus_a_i),
		.viking_enable_i (viking_enable),
		.steroids_i      (mode.steroids),
		.viking_active_o (viking_active_o)
	);

	upload_writer u_upload (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.bus_cycle_i    (bus_cycle_i),
		.mhz8_en1_i     (mhz8_en1_i),
		.dio_strobe_i   (dio_strobe_i),
		.dio_download_i (dio_download_i),
		.dio_addr_i     (dio_addr_i),
		.data_wr_o      (data_wr),
		.tos192k_o      (tos192k_o)
	);

	ram_window u_window (
		.ram_a_i         (ram_a_i),
		.mem_size_i      (mem_size),
		.viking_enable_i (viking_enable),
		.steroids_i      (mode.steroids),
		.mbus_a_i        (mbus_a_i),
		.rom2_n_i        (rom2_n_i),
		.tos192k_i       (tos192k_o),
		.ram_en_o        (ram_req_ok),
		.rom_addr_o      (rom_addr_o)
	);

	sdram_port_mux u_mux (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.bus_cycle_i     (bus_cycle_i),
		.dio_download_i  (dio_download_i),
		.data_wr_i       (data_wr),
		.dio_addr_i      (dio_addr_i),
		.dio_data_i      (dio_data_i),
		.viking_active_i (viking_active_o),
		.viking_read_i   (viking_read_i),
		.viking_vaddr_i  (viking_vaddr_i),
		.ras_n_i         (ras_n_i),
		.ram_a_i         (ram_a_i),
		.ram_en_i        (ram_req_ok),
		.ram_we_n_i      (ram_we_n_i),
		.ram_ds_i        (ram_ds_i),
		.ram_din_i       (ram_din_i),
		.sdram_addr_o    (sdram_addr_o),
		.sdram_req_o     (sdram_req_o),
		.sdram_we_o      (sdram_we_o),
		.sdram_ds_o      (sdram_ds_o),
		.sdram_din_o     (sdram_din_o)
	);

endmodule

`default_nettype wire

//--- verilog/sdram_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_mux
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  bus_cycle_t bus_cycle_i,
	input  logic       dio_download_i,
	input  logic       data_wr_i,      // upload write pulse
	input  word_addr_t dio_addr_i,
	input  data_t      dio_data_i,
	input  logic       viking_active_i,
	input  logic       viking_read_i,
	input  word_addr_t viking_vaddr_i,
	input  logic       ras_n_i,        // ras0_n & ras1_n from mcu
	input  word_addr_t ram_a_i,
	input  logic       ram_en_i,       // address inside the window
	input  logic       ram_we_n_i,
	input  ds_t        ram_ds_i,
	input  data_t      ram_din_i,
	output word_addr_t sdram_addr_o,
	output logic       sdram_req_o,
	output logic       sdram_we_o,
	output ds_t        sdram_ds_o,
	output data_t      sdram_din_o
);

	logic ras_n_d;     // ras one clock back
	logic ram_req;     // chipset access start
	logic upload_sel;
	logic viking_sel;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_d <= 1'b1; // idle high, no edge out of reset
		else
			ras_n_d <= ras_n_i;
	end

	// falling ras, address 0 is never a real access
	assign ram_req = ras_n_d & ~ras_n_i & (|ram_a_i);

	// upload steals the cpu slot while downloading
	assign upload_sel = (bus_cycle_i == CPU) & dio_download_i;
	// viking fetch shares the shifter slot
	assign viking_sel = (bus_cycle_i == VIKING) & viking_active_i & viking_read_i;

	always_comb begin
		if (upload_sel) begin
			sdram_addr_o = dio_addr_i;
			sdram_req_o  = data_wr_i;
			sdram_we_o   = 1'b1;
			sdram_ds_o   = 2'b11;      // full words only
		end else if (viking_sel) begin
			sdram_addr_o = viking_vaddr_i;
			sdram_req_o  = 1'b1;
			sdram_we_o   = 1'b0;       // video fetch is read only
			sdram_ds_o   = ram_ds_i;
		end else begin
			sdram_addr_o = ram_a_i;
			sdram_req_o  = ram_req & ram_en_i;
			sdram_we_o   = ~ram_we_n_i;
			sdram_ds_o   = ram_ds_i;
		end
	end

	// cpu is held during download, so data can follow download alone
	assign sdram_din_o = dio_download_i ? dio_data_i : ram_din_i;

endmodule

`default_nettype wire

//--- verilog/ram_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "st_mem_params.svh"

module ram_window
	import st_cfg_pkg::*;
	import st_bus_pkg::*;
(
	input  word_addr_t ram_a_i,         // chipset ram address
	input  mem_size_t  mem_size_i,
	input  logic       viking_enable_i,
	input  logic       steroids_i,
	input  word_addr_t mbus_a_i,        // cpu/blitter address
	input  logic       rom2_n_i,        // tos rom select
	input  logic       tos192k_i,
	output logic       ram_en_o,
	output word_addr_t rom_addr_o
);

	localparam logic [5:0] WIN_LO   = `VIKING_WIN_LO;
	localparam logic [5:0] WIN_HI   = `VIKING_WIN_HI;
	localparam logic [5:0] BASE_192 = `ROM_BASE_192;
	localparam logic [5:0] BASE_STD = `ROM_BASE_STD;

	logic       size_ok;    // below configured st ram top
	logic       viking_ok;  // inside video ram window
	logic [5:0] rom_base;

	always_comb begin
		case (mem_size_i)
			MEM_1M:  size_ok = (ram_a_i[23:20] == 4'b0000);
			MEM_2M:  size_ok = (ram_a_i[23:21] == 3'b000);
			MEM_4M:  size_ok = (ram_a_i[23:22] == 2'b00);
			MEM_8M:  size_ok = ~ram_a_i[23];
			MEM_14M: size_ok = ~(ram_a_i[23] & ram_a_i[22] & ram_a_i[21]); // up to $dfffff
			default: size_ok = (ram_a_i[23:19] == 5'b00000); // 512k
		endcase
	end

	// $c00000 is 256k, $e80000 block spans 512k
	assign viking_ok = viking_enable_i & (steroids_i ?
		(ram_a_i[23:19] == WIN_HI[5:1]) :
		(ram_a_i[23:18] == WIN_LO));

	assign ram_en_o = size_ok | viking_ok;

	// 192k tos lives at $fc0000, newer ones at $e00000
	assign rom_base = tos192k_i ? BASE_192 : BASE_STD;

	// low 17 bits index inside the image
	assign rom_addr_o = !rom2_n_i ? {rom_base, mbus_a_i[17:1]} : mbus_a_i;

endmodule

`default_nettype wire

//--- verilog/upload_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "st_mem_params.svh"

module upload_writer
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  bus_cycle_t bus_cycle_i,
	input  logic       mhz8_en1_i,
	input  logic       dio_strobe_i,   // toggles once per uploaded word
	input  logic       dio_download_i,
	input  word_addr_t dio_addr_i,
	output logic       data_wr_o,      // one cycle, lands in the cpu slot
	output logic       tos192k_o
);

	localparam logic [5:0] TOS192 = `TOS192_PREFIX;
	localparam logic [3:0] TOS_STD = `TOS_STD_PREFIX;

	logic strobe_d;   // last sampled strobe level
	logic sample_en;

	// sample right before the cpu slot so the write falls into it
	assign sample_en = (bus_cycle_i == PRECYCLE) & mhz8_en1_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d  <= 1'b0;
			data_wr_o <= 1'b0;
		end else begin
			data_wr_o <= 1'b0; // pulse
			if (sample_en) begin
				strobe_d <= dio_strobe_i;
				if (dio_strobe_i ^ strobe_d)
					data_wr_o <= 1'b1; // level change is one word
			end
		end
	end

	// tos kind follows the upload target
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			tos192k_o <= 1'b0;
		else if (dio_download_i) begin
			if (dio_addr_i[23:18] == TOS192)
				tos192k_o <= 1'b1;     // $fc0000 image
			else if (dio_addr_i[23:20] == TOS_STD)
				tos192k_o <= 1'b0;     // $e00000 image
		end
	end

endmodule

`default_nettype wire

//--- verilog/viking_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "st_mem_params.svh"

module viking_detect
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  logic       soft_reset_i,
	input  logic       mhz8_en1_i,      // 8 MHz bus enable
	input  logic       as_n_i,
	input  word_addr_t mbus_a_i,
	input  logic       viking_enable_i,
	input  logic       steroids_i,
	output logic       viking_active_o
);

	localparam logic [5:0] WIN_LO  = `VIKING_WIN_LO;
	localparam logic [5:0] WIN_HI  = `VIKING_WIN_HI;
	localparam logic [7:0] CNT_MAX = `VIKING_COUNT_MAX;

	logic [7:0] viking_in_use; // saturating access count
	logic [5:0] win_prefix;
	logic       in_window;
	logic       count_en;

	// window moves with steroids
	assign win_prefix = steroids_i ? WIN_HI : WIN_LO;
	assign in_window  = (mbus_a_i[23:18] == win_prefix);

	// one count per cpu bus cycle into the window
	assign count_en = mhz8_en1_i & ~as_n_i & viking_enable_i & in_window &
		(viking_in_use != CNT_MAX);

	// a tos probe touches the area only a few times, the driver
	// hammers it, so only a full count switches video over
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			viking_in_use   <= 8'h00;
			viking_active_o <= 1'b0;
		end else if (soft_reset_i) begin // control word reset bit
			viking_in_use   <= 8'h00;
			viking_active_o <= 1'b0;
		end else begin
			if (count_en)
				viking_in_use <= viking_in_use + 8'd1;
			viking_active_o <= (viking_in_use == CNT_MAX); // sticks, counter saturates
		end
	end

endmodule

`default_nettype wire

//--- verilog/st_cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module st_cfg_decode
	import st_cfg_pkg::*;
(
	input  sys_ctrl_t     system_ctrl_i,
	output mem_size_t     mem_size_o,
	output machine_mode_t mode_o,
	output logic          viking_enable_o,
	output logic          soft_reset_o
);

	logic [2:0] size_code; // raw field
	logic       viking_mem_ok;

	assign size_code = system_ctrl_i[CTRL_MEM_MSB:CTRL_MEM_LSB];

	// ste set by either bit, steroids needs both
	assign mode_o.ste      = system_ctrl_i[CTRL_STE] | system_ctrl_i[CTRL_MSTE];
	assign mode_o.mste     = system_ctrl_i[CTRL_MSTE];
	assign mode_o.steroids = system_ctrl_i[CTRL_STE] & system_ctrl_i[CTRL_MSTE];

	assign soft_reset_o = system_ctrl_i[CTRL_SOFT_RESET];

	always_comb begin
		case (size_code)
			3'd1:    mem_size_o = MEM_1M;
			3'd2:    mem_size_o = MEM_2M;
			3'd3:    mem_size_o = MEM_4M;
			3'd4:    mem_size_o = MEM_8M;
			3'd5:    mem_size_o = MEM_14M;
			default: mem_size_o = MEM_512K; // codes 6,7 fall back to 512k
		endcase
	end

	// viking ram at $c00000 collides with more than 8mb
	assign viking_mem_ok = (mem_size_o != MEM_14M);

	// steroids moves the card to $e80000, always allowed there
	assign viking_enable_o = (system_ctrl_i[CTRL_VIKING_EN] & viking_mem_ok) |
		mode_o.steroids;

endmodule

`default_nettype wire

//--- verilog/st_bus_pkg.sv
`default_nettype none

`include "st_mem_params.svh"

package st_bus_pkg;

	// 68000 word address, a0 does not exist
	typedef logic [`ST_ADDR_W:1] word_addr_t;

	// one bus word
	typedef logic [`ST_DATA_W-1:0] data_t;

	// byte strobes, {uds, lds}
	typedef logic [1:0] ds_t;

	// gstmcu bus slot sequence
	typedef enum logic [1:0] {
		PRECYCLE = 2'd0, // slot before the cpu slot
		CPU      = 2'd1, // cpu owns the ram
		VIKING   = 2'd2, // shifter slot, also used by viking fetch
		OTHER    = 2'd3
	} bus_cycle_t;

endpackage

`default_nettype wire

//--- verilog/st_cfg_pkg.sv
`default_nettype none

package st_cfg_pkg;

	// control word as delivered by data_io
	typedef logic [31:0] sys_ctrl_t;

	// bit positions inside the control word
	localparam int CTRL_SOFT_RESET = 0;
	localparam int CTRL_MEM_LSB    = 1; // ram size code, 3 bits
	localparam int CTRL_MEM_MSB    = 3;
	localparam int CTRL_STE        = 23;
	localparam int CTRL_MSTE       = 24;
	localparam int CTRL_VIKING_EN  = 28;

	// ram size, same coding as bits 3..1
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_t;

	// machine flavour
	typedef struct packed {
		logic ste;      // ste or mega ste
		logic mste;     // mega ste
		logic steroids; // both bits, ste on steroids
	} machine_mode_t;

endpackage

`default_nettype wire

//--- include/st_mem_params.svh
`ifndef ST_MEM_PARAMS_SVH
`define ST_MEM_PARAMS_SVH

// bus widths, word address covers bits 23 down to 1
`define ST_ADDR_W 23
`define ST_DATA_W 16

// cpu accesses needed before the viking card counts as in use
`define VIKING_COUNT_MAX 8'd255

// viking video ram windows, address bits 23..18
`define VIKING_WIN_LO 6'b110000 // $c00000, normal st ram layout
`define VIKING_WIN_HI 6'b111010 // $e80000, steroids layout

// upload address prefixes telling the tos kind apart
`define TOS192_PREFIX 6'b111111  // bits 23..18, 192k image at $fc0000
`define TOS_STD_PREFIX 4'he      // bits 23..20, 256k+ image at $e00000

// rom remap bases, address bits 23..18
`define ROM_BASE_192 6'b111111
`define ROM_BASE_STD 6'b111000

`endif
